/* verilog/tri_pkg.sv */
package tri_pkg;

    // Address width on the ao486 side of the transducer
    localparam int CORE_ADDR_W = 32;

    // Width of one L1.5 data word
    localparam int L15_WORD_W = 64;

    // Field widths of the L1.5 request and return headers
    localparam int RQTYPE_W = 5;
    localparam int RETTYPE_W = 4;

    // Request type for an instruction miss
    localparam logic [RQTYPE_W-1:0] IMISS_RQ = 5'd16;

    // Return types that the transducer reacts to
    localparam logic [RETTYPE_W-1:0] IFILL_RET = 4'd1;
    localparam logic [RETTYPE_W-1:0] INT_RET = 4'd7;

    // Interrupt packet type that wakes the core
    localparam logic [1:0] INT_TYPE_WAKE = 2'd1;

    // Request size code for a 4-byte access
    localparam logic [2:0] SZ_4B = 3'd2;

    // One IFILL return carries a whole block of this many bytes
    localparam int BLOCK_BYTES = 32;

    // Code line towards the core and the partial words it is streamed in
    localparam int LINE_W = 128;
    localparam int PARTIAL_W = 32;

    // One L1.5 response word, seen either as raw bytes or as an interrupt packet
    // Byte view is big-endian, so bytes[7] holds the lowest addressed byte
    typedef union packed {
        logic [7:0][7:0] bytes;
        struct packed {
            logic [45:0] unused_hi;
            logic [1:0]  int_type;
            logic [15:0] unused_lo;
        } intr;
    } l15_word_u;

endpackage

/* verilog/ifill_request_ctrl.sv */
`timescale 1ns/1ps

module ifill_request_ctrl import tri_pkg::*; #(
    parameter int L15_ADDR_W = 40
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   request_readcode_do,
    input  logic [CORE_ADDR_W-1:0] request_readcode_address,
    input  logic                   l15_transducer_val,
    input  logic                   l15_transducer_header_ack,
    input  logic [RETTYPE_W-1:0]   l15_transducer_returntype,
    input  logic                   line_done,
    output logic                   transducer_l15_val,
    output logic [RQTYPE_W-1:0]    transducer_l15_rqtype,
    output logic [L15_ADDR_W-1:0]  transducer_l15_address,
    output logic [1:0]             window_offset,
    output logic                   second_half,
    output logic                   last_return
);

    // Lowest address bit above the byte offset inside a block
    localparam int BLK_LSB = $clog2(BLOCK_BYTES);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_REQ       = 2'd1;
    localparam logic [1:0] ST_WAIT_RET  = 2'd2;
    localparam logic [1:0] ST_WAIT_DONE = 2'd3;

    logic [1:0]             state;
    logic                   val_q;
    logic                   split_q;
    logic                   second_q;
    logic [1:0]             offset_q;
    logic [CORE_ADDR_W-1:0] blk_addr;
    logic [CORE_ADDR_W-1:0] fetch_blk;
    logic                   ifill_ret;
    logic                   go_second;

    assign ifill_ret = l15_transducer_val && (l15_transducer_returntype == IFILL_RET);

    // Base of the block holding the first fetched byte
    assign fetch_blk = request_readcode_address & ~CORE_ADDR_W'(BLOCK_BYTES - 1);

    // The first half of a split has come back, so the next block must be asked for
    assign go_second = (state == ST_WAIT_RET) && ifill_ret && split_q && !second_q;

    // Control FSM, one or two val/header_ack exchanges per fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            val_q    <= 1'b0;
            split_q  <= 1'b0;
            second_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (request_readcode_do) begin
                        state    <= ST_REQ;
                        val_q    <= 1'b1;
                        second_q <= 1'b0;
                        // Window starts in the last 8 bytes, so it runs into the next block
                        split_q  <= &request_readcode_address[BLK_LSB-1 -: 2];
                    end
                end
                ST_REQ: begin
                    // Val holds under back-pressure and drops right after the ack
                    if (l15_transducer_header_ack) begin
                        state <= ST_WAIT_RET;
                        val_q <= 1'b0;
                    end
                end
                ST_WAIT_RET: begin
                    if (go_second) begin
                        state    <= ST_REQ;
                        val_q    <= 1'b1;
                        second_q <= 1'b1;
                    end else if (ifill_ret) begin
                        state <= ST_WAIT_DONE;
                    end
                end
                default: begin
                    // Streaming to the core must finish before the next fetch
                    if (line_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Address and window offset are latched once per fetch
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && request_readcode_do) begin
            blk_addr <= fetch_blk;
            offset_q <= request_readcode_address[BLK_LSB-1 -: 2];
        end else if (go_second) begin
            blk_addr <= blk_addr + CORE_ADDR_W'(BLOCK_BYTES);
        end
    end

    assign transducer_l15_val = val_q;
    assign transducer_l15_rqtype = val_q ? IMISS_RQ : '0;

    // Block address is sign-extended up to the L1.5 address width
    assign transducer_l15_address = L15_ADDR_W'($signed(blk_addr));

    assign window_offset = offset_q;
    assign second_half = second_q;
    assign last_return = !split_q || second_q;

endmodule

/* verilog/ifill_line_assembler.sv */
`timescale 1ns/1ps

module ifill_line_assembler import tri_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  l15_transducer_val,
    input  logic [RETTYPE_W-1:0]  l15_transducer_returntype,
    input  logic [L15_WORD_W-1:0] l15_transducer_data_0,
    input  logic [L15_WORD_W-1:0] l15_transducer_data_1,
    input  logic [L15_WORD_W-1:0] l15_transducer_data_2,
    input  logic [L15_WORD_W-1:0] l15_transducer_data_3,
    input  logic                  second_half,
    input  logic                  last_return,
    input  logic [1:0]            window_offset,
    output logic                  line_valid,
    output logic [LINE_W-1:0]     line
);

    localparam int BLOCK_BITS = 8 * BLOCK_BYTES;

    l15_word_u              ret_word [4];
    logic [BLOCK_BITS-1:0]  cur_blk;
    logic [BLOCK_BITS-1:0]  first_q;
    logic [2*BLOCK_BITS-1:0] joined;
    logic                   ifill_ret;

    assign ifill_ret = l15_transducer_val && (l15_transducer_returntype == IFILL_RET);

    assign ret_word[0] = l15_transducer_data_0;
    assign ret_word[1] = l15_transducer_data_1;
    assign ret_word[2] = l15_transducer_data_2;
    assign ret_word[3] = l15_transducer_data_3;

    // Reorder the block so that byte k lands in bits 8k+7 to 8k
    // The L1.5 sends each word with its lowest addressed byte in the top bits
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            for (int b = 0; b < 8; b++) begin
                cur_blk[(8*w + b)*8 +: 8] = ret_word[w].bytes[7-b];
            end
        end
    end

    // Keep the first block of a split until its partner arrives
    always_ff @(posedge clk) begin
        if (ifill_ret && !second_half) begin
            first_q <= cur_blk;
        end
    end

    // For a split the current block is the upper half of the 64-byte pair
    // Without a split the window never reaches the upper half
    assign joined = {cur_blk, second_half ? first_q : cur_blk};

    // Window is 16 bytes from an 8-byte aligned start
    always_ff @(posedge clk) begin
        if (ifill_ret && last_return) begin
            line <= joined[int'(window_offset) * 64 +: LINE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= ifill_ret && last_return;
        end
    end

endmodule

/* verilog/readcode_streamer.sv */
`timescale 1ns/1ps

module readcode_streamer import tri_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 line_valid,
    input  logic [LINE_W-1:0]    line,
    output logic [PARTIAL_W-1:0] transducer_ao486_readcode_partial,
    output logic [LINE_W-1:0]    transducer_ao486_readcode_line,
    output logic                 transducer_ao486_readcode_partial_done,
    output logic                 transducer_ao486_request_readcode_done
);

    logic [1:0]        word_cnt;
    logic              active;
    logic [LINE_W-1:0] line_q;

    // Four partial words go out on consecutive cycles after the line arrives
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            word_cnt <= 2'd0;
        end else if (line_valid) begin
            active   <= 1'b1;
            word_cnt <= 2'd0;
        end else if (active) begin
            word_cnt <= word_cnt + 2'd1;
            // Last word shown, stop here
            if (word_cnt == 2'd3) begin
                active <= 1'b0;
            end
        end
    end

    // The core keeps reading the line after streaming, so hold it until the next one
    always_ff @(posedge clk) begin
        if (line_valid) begin
            line_q <= line;
        end
    end

    // Word 0 sits in the low bits of the line
    assign transducer_ao486_readcode_partial = line_q[int'(word_cnt) * PARTIAL_W +: PARTIAL_W];
    assign transducer_ao486_readcode_line = line_q;
    assign transducer_ao486_readcode_partial_done = active;

    // Done comes with the fourth word and also releases the request controller
    assign transducer_ao486_request_readcode_done = active && (word_cnt == 2'd3);

endmodule

/* verilog/int_wake_detect.sv */
`timescale 1ns/1ps

module int_wake_detect import tri_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  l15_transducer_val,
    input  logic [RETTYPE_W-1:0]  l15_transducer_returntype,
    input  logic [L15_WORD_W-1:0] l15_transducer_data_0,
    output logic                  ao486_int
);

    l15_word_u int_word;
    logic      wake_hit;

    assign int_word = l15_transducer_data_0;

    // Only an interrupt return of wake type counts, everything else is ignored
    assign wake_hit = l15_transducer_val
                   && (l15_transducer_returntype == INT_RET)
                   && (int_word.intr.int_type == INT_TYPE_WAKE);

    // One-cycle pulse in the cycle after the return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ao486_int <= 1'b0;
        end else begin
            ao486_int <= wake_hit;
        end
    end

endmodule

/* verilog/tri_top.sv */
`timescale 1ns/1ps

module ao486_l15_tri import tri_pkg::*; #(
    parameter int L15_ADDR_W = 40
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Code fetch requests from the core
    input  logic                   request_readcode_do,
    input  logic [CORE_ADDR_W-1:0] request_readcode_address,

    // Request channel towards the L1.5
    output logic                   transducer_l15_val,
    output logic [RQTYPE_W-1:0]    transducer_l15_rqtype,
    output logic [L15_ADDR_W-1:0]  transducer_l15_address,
    output logic [2:0]             transducer_l15_size,
    input  logic                   l15_transducer_header_ack,

    // Response channel from the L1.5
    input  logic                   l15_transducer_val,
    input  logic [RETTYPE_W-1:0]   l15_transducer_returntype,
    input  logic [L15_WORD_W-1:0]  l15_transducer_data_0,
    input  logic [L15_WORD_W-1:0]  l15_transducer_data_1,
    input  logic [L15_WORD_W-1:0]  l15_transducer_data_2,
    input  logic [L15_WORD_W-1:0]  l15_transducer_data_3,
    output logic                   transducer_l15_req_ack,

    // Code line and status back to the core
    output logic [PARTIAL_W-1:0]   transducer_ao486_readcode_partial,
    output logic [LINE_W-1:0]      transducer_ao486_readcode_line,
    output logic                   transducer_ao486_readcode_partial_done,
    output logic                   transducer_ao486_request_readcode_done,
    output logic                   ao486_int
);

    logic [1:0]        window_offset;
    logic              second_half;
    logic              last_return;
    logic              line_valid;
    logic [LINE_W-1:0] line;

    // Every fetch asks for a 4-byte access, the L1.5 returns the full block anyway
    assign transducer_l15_size = SZ_4B;

    // Responses are always consumed in the cycle they arrive
    assign transducer_l15_req_ack = l15_transducer_val;

    ifill_request_ctrl #(
        .L15_ADDR_W(L15_ADDR_W)
    ) i_ifill_request_ctrl (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .request_readcode_do       (request_readcode_do),
        .request_readcode_address  (request_readcode_address),
        .l15_transducer_val        (l15_transducer_val),
        .l15_transducer_header_ack (l15_transducer_header_ack),
        .l15_transducer_returntype (l15_transducer_returntype),
        .line_done                 (transducer_ao486_request_readcode_done),
        .transducer_l15_val        (transducer_l15_val),
        .transducer_l15_rqtype     (transducer_l15_rqtype),
        .transducer_l15_address    (transducer_l15_address),
        .window_offset             (window_offset),
        .second_half               (second_half),
        .last_return               (last_return)
    );

    ifill_line_assembler i_ifill_line_assembler (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .l15_transducer_val        (l15_transducer_val),
        .l15_transducer_returntype (l15_transducer_returntype),
        .l15_transducer_data_0     (l15_transducer_data_0),
        .l15_transducer_data_1     (l15_transducer_data_1),
        .l15_transducer_data_2     (l15_transducer_data_2),
        .l15_transducer_data_3     (l15_transducer_data_3),
        .second_half               (second_half),
        .last_return               (last_return),
        .window_offset             (window_offset),
        .line_valid                (line_valid),
        .line                      (line)
    );

    readcode_streamer i_readcode_streamer (
        .clk                                    (clk),
        .rst_n                                  (rst_n),
        .line_valid                             (line_valid),
        .line                                   (line),
        .transducer_ao486_readcode_partial      (transducer_ao486_readcode_partial),
        .transducer_ao486_readcode_line         (transducer_ao486_readcode_line),
        .transducer_ao486_readcode_partial_done (transducer_ao486_readcode_partial_done),
        .transducer_ao486_request_readcode_done (transducer_ao486_request_readcode_done)
    );

    int_wake_detect i_int_wake_detect (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .l15_transducer_val        (l15_transducer_val),
        .l15_transducer_returntype (l15_transducer_returntype),
        .l15_transducer_data_0     (l15_transducer_data_0),
        .ao486_int                 (ao486_int)
    );

endmodule

/* bench/tri_sva.sv */
`timescale 1ns/1ps

module tri_sva #(
    parameter int L15_ADDR_W = 40
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  transducer_l15_val,
    input logic [L15_ADDR_W-1:0] transducer_l15_address,
    input logic                  l15_transducer_header_ack,
    input logic                  ao486_int,
    input logic                  transducer_ao486_readcode_partial_done,
    input logic                  transducer_ao486_request_readcode_done
);

    int unsigned err_cnt = 0;

    // A request stays up with a stable address until the L1.5 takes its header
    val_hold: assert property (@(posedge clk) disable iff (!rst_n)
        transducer_l15_val && !l15_transducer_header_ack
        |=> transducer_l15_val && $stable(transducer_l15_address))
        else begin
            $error("request val or address changed before header_ack");
            err_cnt++;
        end

    // The wake interrupt to the core is a single-cycle pulse
    int_single: assert property (@(posedge clk) disable iff (!rst_n)
        ao486_int |=> !ao486_int)
        else begin
            $error("ao486_int stayed high for two cycles");
            err_cnt++;
        end

    // Done comes with the fourth partial word, after three words already shown
    done_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
        transducer_ao486_request_readcode_done |->
            transducer_ao486_readcode_partial_done
            && $past(transducer_ao486_readcode_partial_done, 1)
            && $past(transducer_ao486_readcode_partial_done, 2)
            && $past(transducer_ao486_readcode_partial_done, 3))
        else begin
            $error("readcode done outside the fourth partial word");
            err_cnt++;
        end

endmodule

/* bench/tri_tb.sv */
`timescale 1ns/1ps

module tri_tb import tri_pkg::*; ();

    localparam int L15_ADDR_W = 40;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS = 6;

    logic                   clk;
    logic                   rst_n;
    logic                   request_readcode_do;
    logic [CORE_ADDR_W-1:0] request_readcode_address;
    logic                   transducer_l15_val;
    logic [RQTYPE_W-1:0]    transducer_l15_rqtype;
    logic [L15_ADDR_W-1:0]  transducer_l15_address;
    logic [2:0]             transducer_l15_size;
    logic                   l15_transducer_header_ack;
    logic                   l15_transducer_val;
    logic [RETTYPE_W-1:0]   l15_transducer_returntype;
    logic [L15_WORD_W-1:0]  l15_transducer_data_0;
    logic [L15_WORD_W-1:0]  l15_transducer_data_1;
    logic [L15_WORD_W-1:0]  l15_transducer_data_2;
    logic [L15_WORD_W-1:0]  l15_transducer_data_3;
    logic                   transducer_l15_req_ack;
    logic [PARTIAL_W-1:0]   transducer_ao486_readcode_partial;
    logic [LINE_W-1:0]      transducer_ao486_readcode_line;
    logic                   transducer_ao486_readcode_partial_done;
    logic                   transducer_ao486_request_readcode_done;
    logic                   ao486_int;
    integer                 seed = 66596;

    ao486_l15_tri #(.L15_ADDR_W(L15_ADDR_W)) i_ao486_l15_tri (.*);

    bind ao486_l15_tri tri_sva #(.L15_ADDR_W(L15_ADDR_W)) i_tri_sva (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Memory contents of the L1.5 model, every address bit takes part
    function automatic logic [7:0] byte_at(input logic [31:0] a);
        return {a[4:0], a[7:5]} ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    // Data word w of a block, lowest addressed byte in the top bits
    function automatic logic [63:0] block_word(input logic [31:0] blk, input int w);
        logic [63:0] v;
        for (int j = 0; j < 8; j++) begin
            v[63-8*j -: 8] = byte_at(blk + 32'(8*w + j));
        end
        return v;
    endfunction

    // Partial word i of the window, lowest byte in bits 7:0
    function automatic logic [31:0] window_word(input logic [31:0] start, input int i);
        logic [31:0] v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = byte_at(start + 32'(4*i + b));
        end
        return v;
    endfunction

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // L1.5 side of one IMISS exchange, header_ack and then the IFILL return
    task automatic serve_imiss(input logic [31:0] blk, input int extra_wait);
        logic [L15_ADDR_W-1:0] exp_addr;
        int                    ack_wait;
        int                    ret_wait;
        exp_addr = {{(L15_ADDR_W-32){blk[31]}}, blk};
        ack_wait = extra_wait + int'($unsigned($random(seed)) % 3);
        ret_wait = int'($unsigned($random(seed)) % 4);
        while (!transducer_l15_val) @(negedge clk);
        check(transducer_l15_rqtype, IMISS_RQ, "request type");
        check(transducer_l15_size, SZ_4B, "request size");
        check(transducer_l15_address, exp_addr, "request address");
        repeat (ack_wait) begin
            @(negedge clk);
            check(transducer_l15_val, 1'b1, "val held before header_ack");
            check(transducer_l15_address, exp_addr, "address held before header_ack");
        end
        l15_transducer_header_ack = 1'b1;
        @(negedge clk);
        l15_transducer_header_ack = 1'b0;
        check(transducer_l15_val, 1'b0, "val in the cycle after header_ack");
        repeat (ret_wait) @(negedge clk);
        l15_transducer_val = 1'b1;
        l15_transducer_returntype = IFILL_RET;
        l15_transducer_data_0 = block_word(blk, 0);
        l15_transducer_data_1 = block_word(blk, 1);
        l15_transducer_data_2 = block_word(blk, 2);
        l15_transducer_data_3 = block_word(blk, 3);
        @(posedge clk);
        check(transducer_l15_req_ack, 1'b1, "req_ack with response val");
        @(negedge clk);
        l15_transducer_val = 1'b0;
        @(posedge clk);
        check(transducer_l15_req_ack, 1'b0, "req_ack without response val");
        @(negedge clk);
    endtask

    // One whole code fetch, checked word by word against the window
    task automatic fetch_line(input logic [31:0] addr, input int extra_wait);
        logic [31:0]  start;
        logic [31:0]  blk;
        logic [127:0] exp_line;
        int           idx;
        logic         finished;
        start = addr & ~32'd7;
        blk = addr & ~32'(BLOCK_BYTES - 1);
        for (int i = 0; i < 4; i++) begin
            exp_line[32*i +: 32] = window_word(start, i);
        end
        @(negedge clk);
        request_readcode_do = 1'b1;
        request_readcode_address = addr;
        @(negedge clk);
        request_readcode_do = 1'b0;
        serve_imiss(blk, extra_wait);
        // A window in the last 8 bytes of the block needs the next block too
        if (addr[4:3] == 2'd3) begin
            serve_imiss(blk + 32'(BLOCK_BYTES), extra_wait);
        end
        idx = 0;
        do begin
            if (transducer_ao486_readcode_partial_done) begin
                check(transducer_ao486_readcode_partial, exp_line[32*idx +: 32], "partial word");
                idx++;
            end
            finished = transducer_ao486_request_readcode_done;
            if (!finished) @(negedge clk);
        end while (!finished);
        check(idx, 4, "partial words up to done");
        check(transducer_ao486_readcode_line, exp_line, "code line");
        @(negedge clk);
        check(transducer_ao486_request_readcode_done, 1'b0, "single done pulse");
        check(transducer_l15_val, 1'b0, "no extra request");
    endtask

    // Non-IFILL return and the interrupt pulse it should or should not raise
    task automatic send_return(input logic [3:0] rtype, input logic [1:0] itype,
                               input logic exp_int);
        l15_transducer_val = 1'b1;
        l15_transducer_returntype = rtype;
        l15_transducer_data_0 = {$random(seed), $random(seed)};
        l15_transducer_data_0[17:16] = itype;
        @(negedge clk);
        l15_transducer_val = 1'b0;
        check(ao486_int, exp_int, "interrupt after return");
        @(negedge clk);
        check(ao486_int, 1'b0, "interrupt one cycle later");
    endtask

    task automatic aligned_fetch();
        fetch_line(32'h0000_1000, 0);
    endtask

    task automatic offset_fetch();
        fetch_line(32'h0000_2048, 0);
        fetch_line(32'h0000_2053, 0);
    endtask

    task automatic split_fetch();
        fetch_line(32'h8000_3018, 0);
        fetch_line(32'h0000_401d, 0);
    endtask

    task automatic delayed_ack();
        fetch_line(32'h0001_5010, 6);
    endtask

    task automatic interrupt_returns();
        send_return(INT_RET, INT_TYPE_WAKE, 1'b1);
        send_return(INT_RET, 2'd0, 1'b0);
        send_return(INT_RET, 2'd2, 1'b0);
        send_return(INT_RET, 2'd3, 1'b0);
        send_return(4'd0, INT_TYPE_WAKE, 1'b0);
        send_return(4'd3, INT_TYPE_WAKE, 1'b0);
    endtask

    task automatic reset_values();
        // A fetch in flight and a wake return on the bus give reset something to clear
        @(negedge clk);
        request_readcode_do = 1'b1;
        request_readcode_address = 32'h0000_6000;
        @(negedge clk);
        request_readcode_do = 1'b0;
        check(transducer_l15_val, 1'b1, "val before reset");
        l15_transducer_val = 1'b1;
        l15_transducer_returntype = INT_RET;
        l15_transducer_data_0 = '0;
        l15_transducer_data_0[17:16] = INT_TYPE_WAKE;
        rst_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check(ao486_int, 1'b0, "interrupt during reset");
        end
        l15_transducer_val = 1'b0;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check(transducer_l15_val, 1'b0, "val after reset");
            check(transducer_l15_rqtype, '0, "rqtype after reset");
            check(transducer_ao486_readcode_partial_done, 1'b0, "partial_done after reset");
            check(transducer_ao486_request_readcode_done, 1'b0, "done after reset");
            check(ao486_int, 1'b0, "interrupt after reset");
        end
    endtask

    // Each test gets 200 cycles before the run is called hung
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        request_readcode_do = 1'b0;
        request_readcode_address = '0;
        l15_transducer_header_ack = 1'b0;
        l15_transducer_val = 1'b0;
        l15_transducer_returntype = '0;
        l15_transducer_data_0 = '0;
        l15_transducer_data_1 = '0;
        l15_transducer_data_2 = '0;
        l15_transducer_data_3 = '0;
        reset_dut();
        aligned_fetch();
        offset_fetch();
        split_fetch();
        delayed_ack();
        interrupt_returns();
        reset_values();
        repeat (2) @(negedge clk);
        if (i_ao486_l15_tri.i_tri_sva.err_cnt != 0) begin
            $display("Protocol assertions failed during the run");
            $display("Test failures found");
            $fatal(1, "assertion failures");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* verilog.f */
verilog/tri_pkg.sv
verilog/ifill_request_ctrl.sv
verilog/ifill_line_assembler.sv
verilog/readcode_streamer.sv
verilog/int_wake_detect.sv
verilog/tri_top.sv
bench/tri_sva.sv
bench/tri_tb.sv

/* Bender.yml */
package:
  name: ao486_l15_tri

sources:
  - files:
      - verilog/tri_pkg.sv
      - verilog/ifill_request_ctrl.sv
      - verilog/ifill_line_assembler.sv
      - verilog/readcode_streamer.sv
      - verilog/int_wake_detect.sv
      - verilog/tri_top.sv
  - target: test
    files:
      - bench/tri_sva.sv
      - bench/tri_tb.sv
